// ==== acq_regs.sv ====
module acq_regs (
  input  logic                    adc_clk,
  input  logic                    reset_i,
  input  sys_bus_pkg::offset_t     offset_i,
  input  sys_bus_pkg::bus_data_t   wdata_i,
  input  logic                    wen_i,
  input  logic                    ren_i,
  output sys_bus_pkg::bus_data_t   rdata_o,
  output logic                    ack_o,
  output logic                    err_o,
  input  conv_pkg::adc_sample_t    adc_a_i,    // Converted samples
  input  conv_pkg::adc_sample_t    adc_b_i,
  output conv_pkg::dac_value_t     dac_a_o,    // Values for the DAC path
  output conv_pkg::dac_value_t     dac_b_o
);

  import sys_bus_pkg::*;
  import conv_pkg::*;

  mclk_t mclk_q;        // Master clock counter
  logic  ofs_mapped;    // Offset exists in this block
  logic  ofs_writable;  // Offset accepts writes

  ////////////////////////////////////////
  // Master clock
  ////////////////////////////////////////

  // Zero right after reset, then one step per cycle
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      mclk_q <= '0;
    else
      mclk_q <= mclk_q + mclk_t'(1);
  end

  ////////////////////////////////////////
  // DAC values
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end
    else if (wen_i)
    begin
      if (offset_i == ACQ_DAC_A_OFS)
        dac_a_o <= dac_value_t'(wdata_i[DAC_VAL_BITS-1:0]);   // Low half word
      if (offset_i == ACQ_DAC_B_OFS)
        dac_b_o <= dac_value_t'(wdata_i[DAC_VAL_BITS-1:0]);
    end
  end

  // Offset classes for the error answer
  always_comb
  begin
    ofs_writable = (offset_i == ACQ_DAC_A_OFS) || (offset_i == ACQ_DAC_B_OFS);
    ofs_mapped   = ofs_writable
                || (offset_i == ACQ_ADC_A_OFS)   || (offset_i == ACQ_ADC_B_OFS)
                || (offset_i == ACQ_MCLK_LO_OFS) || (offset_i == ACQ_MCLK_HI_OFS);
  end

  ////////////////////////////////////////
  // Read data and handshake
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    rdata_o <= '0;
    if (ren_i)
    begin
      case (offset_i)
        ACQ_ADC_A_OFS:   rdata_o <= {{(BUS_DATA_BITS-ADC_BITS){adc_a_i[ADC_BITS-1]}}, adc_a_i};
        ACQ_ADC_B_OFS:   rdata_o <= {{(BUS_DATA_BITS-ADC_BITS){adc_b_i[ADC_BITS-1]}}, adc_b_i};
        ACQ_DAC_A_OFS:   rdata_o <= {{(BUS_DATA_BITS-DAC_VAL_BITS){dac_a_o[DAC_VAL_BITS-1]}},
                                     dac_a_o};
        ACQ_DAC_B_OFS:   rdata_o <= {{(BUS_DATA_BITS-DAC_VAL_BITS){dac_b_o[DAC_VAL_BITS-1]}},
                                     dac_b_o};
        ACQ_MCLK_LO_OFS: rdata_o <= mclk_q[31:0];     // Count at the strobe edge
        ACQ_MCLK_HI_OFS: rdata_o <= mclk_q[63:32];
        default:         rdata_o <= '0;
      endcase
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      // Holes on any access, read-only words on a write
      err_o <= (ren_i && !ofs_mapped) || (wen_i && !ofs_writable);
    end
  end

  // Bus master never issues read and write together
  assert property (@(posedge adc_clk) disable iff (reset_i) !(wen_i && ren_i))
    else $error("acq_regs: read and write strobe in the same cycle");

endmodule

// ==== adc_dac_io.sv ====
module adc_dac_io (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  input  conv_pkg::adc_pin_t    adc_dat_a_i,     // Raw ADC pins
  input  conv_pkg::adc_pin_t    adc_dat_b_i,
  input  logic                 digital_loop_i,
  input  conv_pkg::dac_value_t  dac_a_i,         // Signed values from the bus
  input  conv_pkg::dac_value_t  dac_b_i,
  output conv_pkg::adc_sample_t adc_a_o,
  output conv_pkg::adc_sample_t adc_b_o,
  output conv_pkg::dac_word_t   dac_dat_a_o,     // Registered DAC pin words
  output conv_pkg::dac_word_t   dac_dat_b_o
);

  import conv_pkg::*;

  logic [ADC_BITS-1:0] adc_cap_a_q;   // Pin capture
  logic [ADC_BITS-1:0] adc_cap_b_q;
  adc_sample_t         adc_conv_a;
  adc_sample_t         adc_conv_b;

  ////////////////////////////////////////
  // ADC capture and conversion
  ////////////////////////////////////////

  // Only the upper 14 pins carry data
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      adc_cap_a_q <= '0;
      adc_cap_b_q <= '0;
    end
    else
    begin
      adc_cap_a_q <= adc_dat_a_i[PIN_BITS-1:ADC_PIN_LSB];
      adc_cap_b_q <= adc_dat_b_i[PIN_BITS-1:ADC_PIN_LSB];
    end
  end

  // Two's complement, negative slope
  assign adc_conv_a = {adc_cap_a_q[ADC_BITS-1], ~adc_cap_a_q[ADC_BITS-2:0]};
  assign adc_conv_b = {adc_cap_b_q[ADC_BITS-1], ~adc_cap_b_q[ADC_BITS-2:0]};

  // Loopback feeds the DAC words back in as samples
  assign adc_a_o = digital_loop_i ? $signed(dac_dat_a_o) : adc_conv_a;
  assign adc_b_o = digital_loop_i ? $signed(dac_dat_b_o) : adc_conv_b;

  ////////////////////////////////////////
  // DAC words
  ////////////////////////////////////////

  // Signed value to offset word, also negative slope
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else
    begin
      dac_dat_a_o <= {dac_a_i[DAC_VAL_BITS-1], ~dac_a_i[DAC_VAL_BITS-2:DAC_VAL_LSB]};
      dac_dat_b_o <= {dac_b_i[DAC_VAL_BITS-1], ~dac_b_i[DAC_VAL_BITS-2:DAC_VAL_LSB]};
    end
  end

endmodule

// ==== adc_sys_top.sv ====
module adc_sys_top (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  // System bus
  input  sys_bus_pkg::bus_addr_t addr_i,
  input  sys_bus_pkg::bus_data_t wdata_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  output sys_bus_pkg::bus_data_t rdata_o,
  output logic                  ack_o,
  output logic                  err_o,
  // Converters
  input  conv_pkg::adc_pin_t     adc_dat_a_i,
  input  conv_pkg::adc_pin_t     adc_dat_b_i,
  output conv_pkg::dac_word_t    dac_dat_a_o,
  output conv_pkg::dac_word_t    dac_dat_b_o,
  output logic [7:0]            led_o
);

  import sys_bus_pkg::*;
  import conv_pkg::*;

  region_mask_t region_wen, region_ren;
  logic         req_q;
  region_t      region_q;
  bus_data_t    hk_rdata, acq_rdata;
  logic         hk_ack, hk_err, acq_ack, acq_err;
  logic         digital_loop;
  dac_value_t   dac_a, dac_b;     // Values from region 1
  adc_sample_t  adc_a, adc_b;     // Samples into region 1

  ////////////////////////////////////////
  // Bus decode and merge
  ////////////////////////////////////////

  sys_bus_decode sys_bus_decode_inst (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .addr_i (addr_i), .wen_i (wen_i), .ren_i (ren_i),
    .region_wen_o (region_wen), .region_ren_o (region_ren),
    .req_q_o (req_q), .region_q_o (region_q)
  );

  sys_bus_result sys_bus_result_inst (
    .req_q_i (req_q), .region_q_i (region_q),
    .hk_rdata_i (hk_rdata), .hk_ack_i (hk_ack), .hk_err_i (hk_err),
    .acq_rdata_i (acq_rdata), .acq_ack_i (acq_ack), .acq_err_i (acq_err),
    .rdata_o (rdata_o), .ack_o (ack_o), .err_o (err_o)
  );

  ////////////////////////////////////////
  // Register blocks and converter IO
  ////////////////////////////////////////

  hk_regs hk_regs_inst (   // Region 0
    .adc_clk (adc_clk), .reset_i (reset_i),
    .offset_i (addr_i[OFFSET_BITS-1:0]), .wdata_i (wdata_i),
    .wen_i (region_wen[REGION_HK]), .ren_i (region_ren[REGION_HK]),
    .rdata_o (hk_rdata), .ack_o (hk_ack), .err_o (hk_err),
    .digital_loop_o (digital_loop), .led_o (led_o)
  );

  acq_regs acq_regs_inst (   // Region 1
    .adc_clk (adc_clk), .reset_i (reset_i),
    .offset_i (addr_i[OFFSET_BITS-1:0]), .wdata_i (wdata_i),
    .wen_i (region_wen[REGION_ACQ]), .ren_i (region_ren[REGION_ACQ]),
    .rdata_o (acq_rdata), .ack_o (acq_ack), .err_o (acq_err),
    .adc_a_i (adc_a), .adc_b_i (adc_b), .dac_a_o (dac_a), .dac_b_o (dac_b)
  );

  adc_dac_io adc_dac_io_inst (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop), .dac_a_i (dac_a), .dac_b_i (dac_b),
    .adc_a_o (adc_a), .adc_b_o (adc_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// ==== conv_pkg.sv ====
package conv_pkg;

  ////////////////////////////////////////
  // Converter widths
  ////////////////////////////////////////

  localparam int PIN_BITS     = 16;                    // ADC pin bus
  localparam int ADC_PIN_LSB  = 2;                     // Pin bits 1 and 0 not used
  localparam int ADC_BITS     = PIN_BITS - ADC_PIN_LSB;

  localparam int DAC_VAL_BITS = 16;                    // Value as seen on the bus
  localparam int DAC_VAL_LSB  = 2;                     // Low value bits dropped
  localparam int DAC_BITS     = DAC_VAL_BITS - DAC_VAL_LSB;

  localparam int MCLK_BITS    = 64;

  // Raw pin bus from the ADC
  typedef logic        [PIN_BITS-1:0]     adc_pin_t;
  // Two's complement sample
  typedef logic signed [ADC_BITS-1:0]     adc_sample_t;
  // Signed DAC value
  typedef logic signed [DAC_VAL_BITS-1:0] dac_value_t;
  // Offset binary word for the DAC pins
  typedef logic        [DAC_BITS-1:0]     dac_word_t;
  // Free running cycle count
  typedef logic        [MCLK_BITS-1:0]    mclk_t;

endpackage

// ==== hk_regs.sv ====
module hk_regs (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  sys_bus_pkg::offset_t   offset_i,         // Byte offset in region
  input  sys_bus_pkg::bus_data_t wdata_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  output sys_bus_pkg::bus_data_t rdata_o,
  output logic                  ack_o,
  output logic                  err_o,
  output logic                  digital_loop_o,   // ADC inputs from the DAC words
  output logic [7:0]            led_o
);

  import sys_bus_pkg::*;

  ////////////////////////////////////////
  // Control and LED registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (wen_i)
    begin
      case (offset_i)
        HK_CTRL_OFS: digital_loop_o <= wdata_i[0];
        HK_LED_OFS:  led_o          <= wdata_i[7:0];
        default:     ;                                  // ID and holes ignore writes
      endcase
    end
  end

  ////////////////////////////////////////
  // Read data and handshake
  ////////////////////////////////////////

  // Sampled from the state at the strobe edge
  always_ff @(posedge adc_clk)
  begin
    rdata_o <= '0;
    if (ren_i)
    begin
      case (offset_i)
        HK_ID_OFS:   rdata_o <= HK_ID;
        HK_CTRL_OFS: rdata_o <= {{(BUS_DATA_BITS-1){1'b0}}, digital_loop_o};
        HK_LED_OFS:  rdata_o <= {{(BUS_DATA_BITS-8){1'b0}}, led_o};
        default:     rdata_o <= '0;                     // Holes read zero
      endcase
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;   // Single cycle answer
  end

  assign err_o = 1'b0;          // Every offset here is harmless

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_adc_sys_top -f tb.f -o sim_tb \
  || { echo "Build failed"; exit 1; }
./obj_dir/sim_tb | tee /dev/stderr | grep -x "SIMULATION PASSED" > /dev/null \
  && exit 0 || exit 1

// ==== sys_bus_decode.sv ====
module sys_bus_decode (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  sys_bus_pkg::bus_addr_t    addr_i,        // Full bus address
  input  logic                     wen_i,         // Write strobe
  input  logic                     ren_i,         // Read strobe
  output sys_bus_pkg::region_mask_t region_wen_o,  // Per region write strobe
  output sys_bus_pkg::region_mask_t region_ren_o,  // Per region read strobe
  output logic                     req_q_o,       // Request seen last cycle
  output sys_bus_pkg::region_t      region_q_o     // Its region
);

  import sys_bus_pkg::*;

  region_t      region_sel;
  region_mask_t region_mask;

  ////////////////////////////////////////
  // Region select
  ////////////////////////////////////////

  assign region_sel  = addr_i[REGION_LSB +: REGION_BITS];   // Upper address field
  assign region_mask = region_mask_t'(1) << region_sel;     // One-hot

  // Strobes only reach the addressed region
  assign region_wen_o = region_mask & {NUM_REGIONS{wen_i}};
  assign region_ren_o = region_mask & {NUM_REGIONS{ren_i}};

  ////////////////////////////////////////
  // Request stage for the answer merge
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      req_q_o    <= 1'b0;
      region_q_o <= '0;
    end
    else
    begin
      req_q_o    <= wen_i | ren_i;   // Any access gets an ack next cycle
      region_q_o <= region_sel;      // Steers the result mux
    end
  end

  // One region and one direction per cycle
  assert property (@(posedge adc_clk) disable iff (reset_i)
    $onehot0({region_wen_o, region_ren_o}))
    else $error("sys_bus_decode: region strobes not one-hot");

endmodule

// ==== sys_bus_pkg.sv ====
package sys_bus_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  localparam int BUS_ADDR_BITS = 32;
  localparam int BUS_DATA_BITS = 32;

  localparam int REGION_LSB  = 20;                     // Region field is addr[22:20]
  localparam int NUM_REGIONS = 8;
  localparam int REGION_BITS = $clog2(NUM_REGIONS);
  localparam int OFFSET_BITS = 8;                      // Byte offset is addr[7:0]

  typedef logic [BUS_ADDR_BITS-1:0] bus_addr_t;
  typedef logic [BUS_DATA_BITS-1:0] bus_data_t;
  typedef logic [REGION_BITS-1:0]   region_t;
  typedef logic [NUM_REGIONS-1:0]   region_mask_t;     // One bit per region
  typedef logic [OFFSET_BITS-1:0]   offset_t;

  // Region numbers
  localparam region_t REGION_HK  = 3'd0;               // Housekeeping
  localparam region_t REGION_ACQ = 3'd1;               // Acquisition registers

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Housekeeping block
  localparam offset_t HK_ID_OFS   = 8'h00;             // Read only
  localparam offset_t HK_CTRL_OFS = 8'h04;             // Bit 0 is digital loopback
  localparam offset_t HK_LED_OFS  = 8'h08;             // LED byte

  // Acquisition block
  localparam offset_t ACQ_ADC_A_OFS   = 8'h00;         // Read only
  localparam offset_t ACQ_ADC_B_OFS   = 8'h04;         // Read only
  localparam offset_t ACQ_DAC_A_OFS   = 8'h08;
  localparam offset_t ACQ_DAC_B_OFS   = 8'h0C;
  localparam offset_t ACQ_MCLK_LO_OFS = 8'h10;         // Read only
  localparam offset_t ACQ_MCLK_HI_OFS = 8'h14;         // Read only

  localparam bus_data_t HK_ID = 32'h5A11_0016;         // Design ID word

endpackage

// ==== sys_bus_result.sv ====
module sys_bus_result (
  input  logic                  req_q_i,       // Access one cycle ago
  input  sys_bus_pkg::region_t   region_q_i,    // Region of that access
  input  sys_bus_pkg::bus_data_t hk_rdata_i,
  input  logic                  hk_ack_i,
  input  logic                  hk_err_i,
  input  sys_bus_pkg::bus_data_t acq_rdata_i,
  input  logic                  acq_ack_i,
  input  logic                  acq_err_i,
  output sys_bus_pkg::bus_data_t rdata_o,
  output logic                  ack_o,
  output logic                  err_o
);

  import sys_bus_pkg::*;

  ////////////////////////////////////////
  // Answer merge
  ////////////////////////////////////////

  always_comb
  begin
    case (region_q_i)
      REGION_HK:
      begin
        rdata_o = hk_rdata_i;
        ack_o   = hk_ack_i;
        err_o   = hk_err_i;
      end
      REGION_ACQ:
      begin
        rdata_o = acq_rdata_i;
        ack_o   = acq_ack_i;
        err_o   = acq_err_i;
      end
      default:
      begin
        // Unused regions answer here
        rdata_o = '0;
        ack_o   = req_q_i;   // Same single cycle timing as the blocks
        err_o   = 1'b0;      // No error for empty space
      end
    endcase
  end

  // Block acks must line up with the decoder's request stage
  always_comb
  begin
    assert final ($isunknown({req_q_i, ack_o}) || (ack_o == req_q_i))
      else $error("sys_bus_result: ack does not match request");
  end

endmodule

// ==== tb.f ====
sys_bus_pkg.sv
conv_pkg.sv
sys_bus_decode.sv
hk_regs.sv
acq_regs.sv
adc_dac_io.sv
sys_bus_result.sv
adc_sys_top.sv
tb_adc_sys_top.sv

// ==== tb_adc_sys_top.sv ====
module tb_adc_sys_top;

  import sys_bus_pkg::*;
  import conv_pkg::*;

  // About 60 bus accesses of 3 cycles each plus short gaps, so 2000 leaves wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic       adc_clk;
  logic       reset_i;
  bus_addr_t  addr_i;
  bus_data_t  wdata_i;
  logic       wen_i;
  logic       ren_i;
  bus_data_t  rdata_o;
  logic       ack_o;
  logic       err_o;
  adc_pin_t   adc_dat_a_i;
  adc_pin_t   adc_dat_b_i;
  dac_word_t  dac_dat_a_o;
  dac_word_t  dac_dat_b_o;
  logic [7:0] led_o;

  int         error_cnt;
  int         check_cnt;
  int         cycle_cnt;      // Posedges since time zero
  adc_pin_t   pin_a;          // Pin values held on the ADC inputs
  adc_pin_t   pin_b;
  dac_value_t val_a;          // Last DAC values written
  dac_value_t val_b;

  adc_sys_top adc_sys_top_inst (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .addr_i (addr_i), .wdata_i (wdata_i), .wen_i (wen_i), .ren_i (ren_i),
    .rdata_o (rdata_o), .ack_o (ack_o), .err_o (err_o),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o), .led_o (led_o)
  );

  always #4 adc_clk = ~adc_clk;   // Period 8

  // Run limit
  always @(posedge adc_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Expected values and helpers
  ////////////////////////////////////////

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $urandom();
    return r[15:0];
  endfunction

  function automatic bus_addr_t reg_addr(input region_t region, input offset_t ofs);
    return (bus_addr_t'(region) << REGION_LSB) | bus_addr_t'(ofs);
  endfunction

  // 14-bit field sign-extended to a bus word
  function automatic bus_data_t sext14(input logic [13:0] w);
    return {{18{w[13]}}, w};
  endfunction

  // Pin bit 15, then pin bits 14 to 2 inverted
  function automatic bus_data_t adc_read_expect(input adc_pin_t pin);
    logic [13:0] s;
    s = {pin[15], ~pin[14:2]};
    return sext14(s);
  endfunction

  // Value bit 15, then value bits 14 to 2 inverted
  function automatic logic [13:0] dac_word_expect(input dac_value_t v);
    return {v[15], ~v[14:2]};
  endfunction

  task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
    check_cnt++;
    assert (got === exp)
    else
    begin
      error_cnt++;
      $display("FAILED %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input logic exp_err);
    @(negedge adc_clk);
    addr_i  = addr;
    wdata_i = data;
    wen_i   = 1'b1;
    @(negedge adc_clk);                              // Strobe edge has passed
    wen_i = 1'b0;
    check_value("ack_o", 32'(ack_o), 32'h1);
    check_value("err_o", 32'(err_o), 32'(exp_err));
    @(negedge adc_clk);
    check_value("ack_o", 32'(ack_o), 32'h0);         // Pulse lasts one cycle
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output logic err,
                          output int strobe_cyc);
    @(negedge adc_clk);
    addr_i = addr;
    ren_i  = 1'b1;
    @(negedge adc_clk);
    ren_i      = 1'b0;
    strobe_cyc = cycle_cnt;                          // Count at the strobe edge
    data       = rdata_o;
    err        = err_o;
    check_value("ack_o", 32'(ack_o), 32'h1);
    @(negedge adc_clk);
    check_value("ack_o", 32'(ack_o), 32'h0);
  endtask

  task automatic read_check(input bus_addr_t addr, input bus_data_t exp, input string name);
    bus_data_t data;
    logic      err;
    int        cyc;
    bus_read(addr, data, err, cyc);
    check_value(name, data, exp);
    check_value("err_o", 32'(err), 32'h0);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_hk();
    logic [7:0] led;
    check_value("led_o", 32'(led_o), 32'h0);
    check_value("dac_dat_a_o", 32'(dac_dat_a_o), 32'h0);
    check_value("dac_dat_b_o", 32'(dac_dat_b_o), 32'h0);
    check_value("ack_o", 32'(ack_o), 32'h0);
    check_value("err_o", 32'(err_o), 32'h0);
    read_check(reg_addr(REGION_HK, HK_ID_OFS), HK_ID, "rdata_o (HK_ID)");
    led = 8'(rand16() >> 8);
    bus_write(reg_addr(REGION_HK, HK_LED_OFS), {24'h0, led}, 1'b0);
    check_value("led_o", 32'(led_o), 32'(led));
    read_check(reg_addr(REGION_HK, HK_LED_OFS), 32'(led), "rdata_o (LED)");
    bus_write(reg_addr(REGION_HK, HK_CTRL_OFS), 32'h1, 1'b0);
    read_check(reg_addr(REGION_HK, HK_CTRL_OFS), 32'h1, "rdata_o (CTRL)");
    bus_write(reg_addr(REGION_HK, HK_CTRL_OFS), 32'h0, 1'b0);
    read_check(reg_addr(REGION_HK, HK_CTRL_OFS), 32'h0, "rdata_o (CTRL)");
  endtask

  task automatic test_adc();
    for (int i = 0; i < 4; i++)
    begin
      pin_a = rand16();
      pin_b = rand16();
      @(negedge adc_clk);
      adc_dat_a_i = pin_a;                           // Held until the next round
      adc_dat_b_i = pin_b;
      read_check(reg_addr(REGION_ACQ, ACQ_ADC_A_OFS), adc_read_expect(pin_a), "rdata_o (ADC A)");
      read_check(reg_addr(REGION_ACQ, ACQ_ADC_B_OFS), adc_read_expect(pin_b), "rdata_o (ADC B)");
    end
  endtask

  task automatic test_dac();
    for (int i = 0; i < 4; i++)
    begin
      val_a = rand16();
      val_b = rand16();
      bus_write(reg_addr(REGION_ACQ, ACQ_DAC_A_OFS), {16'h0, val_a}, 1'b0);
      check_value("dac_dat_a_o", 32'(dac_dat_a_o), 32'(dac_word_expect(val_a)));
      bus_write(reg_addr(REGION_ACQ, ACQ_DAC_B_OFS), {16'h0, val_b}, 1'b0);
      check_value("dac_dat_b_o", 32'(dac_dat_b_o), 32'(dac_word_expect(val_b)));
      read_check(reg_addr(REGION_ACQ, ACQ_DAC_A_OFS), {{16{val_a[15]}}, val_a}, "rdata_o (DAC A)");
      read_check(reg_addr(REGION_ACQ, ACQ_DAC_B_OFS), {{16{val_b[15]}}, val_b}, "rdata_o (DAC B)");
    end
  endtask

  task automatic test_loopback();
    bus_write(reg_addr(REGION_HK, HK_CTRL_OFS), 32'h1, 1'b0);
    read_check(reg_addr(REGION_ACQ, ACQ_ADC_A_OFS), sext14(dac_word_expect(val_a)),
               "rdata_o (loop A)");
    read_check(reg_addr(REGION_ACQ, ACQ_ADC_B_OFS), sext14(dac_word_expect(val_b)),
               "rdata_o (loop B)");
    bus_write(reg_addr(REGION_HK, HK_CTRL_OFS), 32'h0, 1'b0);
    // Pin samples are back
    read_check(reg_addr(REGION_ACQ, ACQ_ADC_A_OFS), adc_read_expect(pin_a), "rdata_o (ADC A)");
    read_check(reg_addr(REGION_ACQ, ACQ_ADC_B_OFS), adc_read_expect(pin_b), "rdata_o (ADC B)");
  endtask

  task automatic test_mclk();
    bus_data_t lo0;
    bus_data_t lo1;
    logic      err;
    int        cyc0;
    int        cyc1;
    int        gap;
    gap = $urandom_range(0, 20);
    bus_read(reg_addr(REGION_ACQ, ACQ_MCLK_LO_OFS), lo0, err, cyc0);
    repeat (gap) @(negedge adc_clk);
    bus_read(reg_addr(REGION_ACQ, ACQ_MCLK_LO_OFS), lo1, err, cyc1);
    check_value("rdata_o (MCLK delta)", lo1 - lo0, bus_data_t'(cyc1 - cyc0));
    read_check(reg_addr(REGION_ACQ, ACQ_MCLK_HI_OFS), 32'h0, "rdata_o (MCLK HI)");
  endtask

  task automatic test_regions();
    bus_data_t data;
    logic      err;
    int        cyc;
    for (int r = 2; r < NUM_REGIONS; r++)
    begin
      read_check(reg_addr(region_t'(r), offset_t'(rand16())), 32'h0, "rdata_o (unused region)");
    end
    bus_read(reg_addr(REGION_ACQ, 8'h18), data, err, cyc);   // Hole in region 1
    check_value("err_o (unmapped)", 32'(err), 32'h1);
    bus_write(reg_addr(REGION_ACQ, ACQ_ADC_A_OFS), 32'h1234, 1'b1);   // Read-only word
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    adc_clk     = 1'b0;
    reset_i     = 1'b1;
    addr_i      = '0;
    wdata_i     = '0;
    wen_i       = 1'b0;
    ren_i       = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    error_cnt   = 0;
    check_cnt   = 0;
    cycle_cnt   = 0;
    void'($urandom(32'hf29e_0df5));
    repeat (5) @(negedge adc_clk);                   // Five reset cycles
    reset_i = 1'b0;

    test_reset_hk();
    test_adc();
    test_dac();
    test_loopback();
    test_mclk();
    test_regions();

    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule
